// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= verilog.f
TB_TOP    ?= tb_wb_stage
RTL_TOP   ?= wb_stage
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= ALL TESTS PASSED
RTL_SRCS  ?= source/wb_pkg.sv \
             source/e_wb_latch.sv \
             source/wb_slot.sv \
             source/wb_commit.sv \
             source/wb_stage.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

# the run passes only if the pass line shows up in the output.
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(OBJ_DIR) -o $(TB_TOP)
	@out="$$($(OBJ_DIR)/$(TB_TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== source/e_wb_latch.sv ====
`default_nettype none

module e_wb_latch #(
    parameter int NUM_SLOTS = wb_pkg::NUM_SLOTS_DEF
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               ld,
    input  logic               clr,
    input  wb_pkg::ex_wb_pkt_t pkt_in,
    output wb_pkg::ex_wb_pkt_t pkt_q,
    output logic               fresh
);
    import wb_pkg::*;

    if (NUM_SLOTS < 1 || NUM_SLOTS > NUM_SLOTS_DEF) begin : g_bad_slots
        $error("e_wb_latch: NUM_SLOTS out of range");
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_q <= '0;
        end else if (clr) begin
            pkt_q.valid <= 1'b0;  // flush leaves a bubble.
        end else if (ld) begin
            pkt_q <= pkt_in;
        end
    end

    // one commit per load; a stall holds the packet but not this flag.
    always_ff @(posedge clk) begin
        if (rst) begin
            fresh <= 1'b0;
        end else begin
            fresh <= ld & ~clr;
        end
    end

    a_ld_clr_excl: assert property (@(posedge clk) disable iff (rst) !(ld && clr))
        else $error("e_wb_latch: ld and clr both high");

endmodule

`default_nettype wire

// ==== source/wb_commit.sv ====
`default_nettype none

module wb_commit #(
    parameter int NUM_SLOTS = wb_pkg::NUM_SLOTS_DEF
) (
    input  logic                           clk,
    input  logic                           rst,
    input  wb_pkg::ex_wb_pkt_t             pkt,
    input  logic                           fresh,
    input  wb_pkg::wb_req_t                req [NUM_SLOTS],
    input  logic [wb_pkg::IDX_W-1:0]       gpr_raddr,
    input  logic [wb_pkg::IDX_W-1:0]       seg_raddr,
    output logic [wb_pkg::GPR_W-1:0]       gpr_rdata,
    output logic [wb_pkg::SEG_W-1:0]       seg_rdata,
    output logic                           mem_wr,
    output logic [wb_pkg::ADDR_W-1:0]      mem_addr,
    output logic [wb_pkg::DATA_W-1:0]      mem_data,
    output logic [wb_pkg::BE_W-1:0]        mem_be,
    output logic                           redirect,
    output logic [wb_pkg::ADDR_W-1:0]      redirect_eip,
    output logic                           exc,
    output logic [wb_pkg::EXC_W-1:0]       exc_type,
    output logic [wb_pkg::ADDR_W-1:0]      exc_eip,
    output logic [wb_pkg::ADDR_W-1:0]      retired_eip,
    output logic [wb_pkg::EFLAGS_W-1:0]    eflags
);
    import wb_pkg::*;

    logic [GPR_W-1:0]     gpr     [GPR_COUNT];
    logic [GPR_W-1:0]     gpr_nxt [GPR_COUNT];
    logic [SEG_W-1:0]     seg     [SEG_COUNT];
    logic [SEG_W-1:0]     seg_nxt [SEG_COUNT];
    logic                 commit;
    logic                 retire;
    logic [NUM_SLOTS-1:0] mem_hit;
    wb_req_t              store_req;

    assign commit = pkt.valid & fresh;
    assign retire = commit & ~pkt.exc;  // exception blocks all state.

    // slot order gives priority, so the last writer of a byte wins.
    always_comb begin
        gpr_nxt   = gpr;
        seg_nxt   = seg;
        store_req = '0;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            mem_hit[s] = (req[s].kind == KIND_MEM);
            if (req[s].kind == KIND_GPR) begin
                for (int b = 0; b < GPR_W / 8; b++) begin
                    if (req[s].be[b]) begin
                        gpr_nxt[req[s].idx][8*b +: 8] = req[s].data[8*b +: 8];
                    end
                end
            end
            if (req[s].kind == KIND_SEG && req[s].idx < SEG_COUNT) begin
                for (int b = 0; b < SEG_W / 8; b++) begin
                    if (req[s].be[b]) begin
                        seg_nxt[req[s].idx][8*b +: 8] = req[s].data[8*b +: 8];
                    end
                end
            end
            if (mem_hit[s]) begin
                store_req = req[s];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < GPR_COUNT; r++) begin
                gpr[r] <= '0;
            end
            for (int r = 0; r < SEG_COUNT; r++) begin
                seg[r] <= '0;
            end
            eflags      <= '0;
            retired_eip <= '0;
        end else if (retire) begin
            gpr         <= gpr_nxt;
            seg         <= seg_nxt;
            eflags      <= pkt.eflags;
            retired_eip <= pkt.eip;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wr   <= 1'b0;
            redirect <= 1'b0;
            exc      <= 1'b0;
        end else begin
            mem_wr   <= retire & (|mem_hit);
            redirect <= retire & pkt.br_valid & ~pkt.br_correct;
            exc      <= commit & pkt.exc;
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            mem_addr     <= store_req.addr;
            mem_data     <= store_req.data;
            mem_be       <= store_req.be;
            redirect_eip <= pkt.br_taken ? pkt.br_fip : pkt.br_fip_p1;
        end
        if (commit) begin
            exc_type <= pkt.exc_type;
            exc_eip  <= pkt.eip;
        end
    end

    assign gpr_rdata = gpr[gpr_raddr];
    assign seg_rdata = (seg_raddr < SEG_COUNT) ? seg[seg_raddr] : '0;

    // the store port takes one request per instruction.
    a_one_store: assert property (@(posedge clk) disable iff (rst)
        commit |-> $countones(mem_hit) <= 1)
        else $error("wb_commit: more than one store in a packet");

endmodule

`default_nettype wire

// ==== source/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

    localparam int NUM_SLOTS_DEF = 4;
    localparam int GPR_COUNT     = 8;
    localparam int SEG_COUNT     = 6;

    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 64;
    localparam int BE_W     = DATA_W / 8;
    localparam int GPR_W    = 32;
    localparam int SEG_W    = 16;
    localparam int IDX_W    = 3;
    localparam int EFLAGS_W = 18;
    localparam int EXC_W    = 4;

    typedef logic [1:0] res_size_t;

    localparam res_size_t SZ_BYTE  = 2'd0;
    localparam res_size_t SZ_WORD  = 2'd1;
    localparam res_size_t SZ_DWORD = 2'd2;
    localparam res_size_t SZ_QWORD = 2'd3;  // memory only.

    typedef struct packed {
        logic [ADDR_W-IDX_W-2:0] pad;
        logic                    hi_byte;  // AH/CH/DH/BH style.
        logic [IDX_W-1:0]        idx;
    } reg_dest_t;

    typedef union packed {
        logic [ADDR_W-1:0] mem_view;
        reg_dest_t         reg_view;
    } dest_u;

    typedef struct packed {
        logic              wb;
        logic              is_reg;
        logic              is_seg;
        logic              is_mem;
        logic [DATA_W-1:0] data;
        dest_u             dest;
    } wb_res_t;

    typedef struct packed {
        logic                            valid;
        logic [ADDR_W-1:0]               eip;
        logic                            exc;
        logic [EXC_W-1:0]                exc_type;
        logic [EFLAGS_W-1:0]             eflags;
        res_size_t                       ressize;
        logic                            br_valid;
        logic                            br_taken;
        logic                            br_correct;
        logic [ADDR_W-1:0]               br_fip_p1;  // fall-through.
        logic [ADDR_W-1:0]               br_fip;     // taken target.
        wb_res_t [NUM_SLOTS_DEF-1:0]     res;
    } ex_wb_pkt_t;

    typedef enum logic [1:0] {
        KIND_NONE,
        KIND_GPR,
        KIND_SEG,
        KIND_MEM
    } wb_kind_t;

    typedef struct packed {
        wb_kind_t          kind;
        logic [IDX_W-1:0]  idx;
        logic [BE_W-1:0]   be;
        logic [DATA_W-1:0] data;  // already in byte lanes.
        logic [ADDR_W-1:0] addr;
    } wb_req_t;

endpackage

`default_nettype wire

// ==== source/wb_slot.sv ====
`default_nettype none

module wb_slot (
    input  wb_pkg::wb_res_t   res,
    input  wb_pkg::res_size_t size,
    output wb_pkg::wb_req_t   req
);
    import wb_pkg::*;

    logic [BE_W-1:0]   be_base;
    logic [BE_W-1:0]   be;
    logic              hi_sel;
    logic [DATA_W-1:0] lane_mask;
    logic [DATA_W-1:0] data_sh;
    wb_kind_t          kind;

    always_comb begin
        case (size)
            SZ_BYTE:  be_base = 8'h01;
            SZ_WORD:  be_base = 8'h03;
            SZ_DWORD: be_base = 8'h0f;
            default:  be_base = 8'hff;
        endcase
    end

    always_comb begin
        if (!res.wb) begin
            kind = KIND_NONE;
        end else if (res.is_mem) begin
            kind = KIND_MEM;
        end else if (res.is_seg) begin
            kind = KIND_SEG;
        end else if (res.is_reg) begin
            kind = KIND_GPR;
        end else begin
            kind = KIND_NONE;
        end
    end

    // high byte only means something for byte writes to a gpr.
    assign hi_sel  = (kind == KIND_GPR) && (size == SZ_BYTE) && res.dest.reg_view.hi_byte;
    assign be      = (kind == KIND_NONE) ? '0 : (hi_sel ? be_base << 1 : be_base);
    assign data_sh = hi_sel ? res.data << 8 : res.data;

    always_comb begin
        for (int b = 0; b < BE_W; b++) begin
            lane_mask[8*b +: 8] = {8{be[b]}};
        end
    end

    assign req.kind = kind;
    assign req.idx  = res.dest.reg_view.idx;
    assign req.be   = be;
    assign req.data = data_sh & lane_mask;
    assign req.addr = res.dest.mem_view;

    // legality of what execute hands over.
    always_comb begin
        if (res.wb) begin
            a_one_kind: assert final ($onehot({res.is_reg, res.is_seg, res.is_mem}))
                else $error("wb_slot: kind bits not one-hot");
            a_qword_mem: assert final (size != SZ_QWORD || res.is_mem)
                else $error("wb_slot: quadword result to a register");
            a_seg_idx: assert final (!res.is_seg || res.dest.reg_view.idx < SEG_COUNT)
                else $error("wb_slot: segment index out of range");
        end
    end

endmodule

`default_nettype wire

// ==== source/wb_stage.sv ====
`default_nettype none

module wb_stage #(
    parameter int NUM_SLOTS = wb_pkg::NUM_SLOTS_DEF
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           ld,
    input  logic                           clr,
    input  wb_pkg::ex_wb_pkt_t             pkt_in,
    input  logic [wb_pkg::IDX_W-1:0]       gpr_raddr,
    input  logic [wb_pkg::IDX_W-1:0]       seg_raddr,
    output logic [wb_pkg::GPR_W-1:0]       gpr_rdata,
    output logic [wb_pkg::SEG_W-1:0]       seg_rdata,
    output logic                           mem_wr,
    output logic [wb_pkg::ADDR_W-1:0]      mem_addr,
    output logic [wb_pkg::DATA_W-1:0]      mem_data,
    output logic [wb_pkg::BE_W-1:0]        mem_be,
    output logic                           redirect,
    output logic [wb_pkg::ADDR_W-1:0]      redirect_eip,
    output logic                           exc,
    output logic [wb_pkg::EXC_W-1:0]       exc_type,
    output logic [wb_pkg::ADDR_W-1:0]      exc_eip,
    output logic [wb_pkg::ADDR_W-1:0]      retired_eip,
    output logic [wb_pkg::EFLAGS_W-1:0]    eflags
);
    import wb_pkg::*;

    ex_wb_pkt_t pkt_q;
    logic       fresh;
    wb_req_t    req [NUM_SLOTS];

    e_wb_latch #(.NUM_SLOTS(NUM_SLOTS)) latch_i (
        .clk    (clk),
        .rst    (rst),
        .ld     (ld),
        .clr    (clr),
        .pkt_in (pkt_in),
        .pkt_q  (pkt_q),
        .fresh  (fresh)
    );

    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
        wb_slot slot_i (
            .res  (pkt_q.res[i]),
            .size (pkt_q.ressize),
            .req  (req[i])
        );
    end

    wb_commit #(.NUM_SLOTS(NUM_SLOTS)) commit_i (
        .clk          (clk),
        .rst          (rst),
        .pkt          (pkt_q),
        .fresh        (fresh),
        .req          (req),
        .gpr_raddr    (gpr_raddr),
        .seg_raddr    (seg_raddr),
        .gpr_rdata    (gpr_rdata),
        .seg_rdata    (seg_rdata),
        .mem_wr       (mem_wr),
        .mem_addr     (mem_addr),
        .mem_data     (mem_data),
        .mem_be       (mem_be),
        .redirect     (redirect),
        .redirect_eip (redirect_eip),
        .exc          (exc),
        .exc_type     (exc_type),
        .exc_eip      (exc_eip),
        .retired_eip  (retired_eip),
        .eflags       (eflags)
    );

endmodule

`default_nettype wire

// ==== verif/wb_model.svh ====
`ifndef WB_MODEL_SVH
`define WB_MODEL_SVH

typedef struct packed {
    logic [GPR_COUNT-1:0][GPR_W-1:0] gpr;
    logic [SEG_COUNT-1:0][SEG_W-1:0] seg;
    logic [EFLAGS_W-1:0]             eflags;
    logic [ADDR_W-1:0]               retired_eip;
} arch_t;

typedef struct packed {
    logic              mem_wr;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_data;
    logic [BE_W-1:0]   mem_be;
    logic              redirect;
    logic [ADDR_W-1:0] redirect_eip;
    logic              exc;
    logic [EXC_W-1:0]  exc_type;
    logic [ADDR_W-1:0] exc_eip;
} strobes_t;

typedef struct packed {
    arch_t    arch;
    strobes_t strb;
} expect_t;

arch_t      arch_q;      // state just after the last edge.
strobes_t   strb_q;
ex_wb_pkt_t pend;        // packet sitting in the latch.
logic       pend_fresh;

// architectural effect of one committed packet.
function automatic expect_t expect_commit(arch_t cur, ex_wb_pkt_t p);
    expect_t    e;
    logic [8:0] lanes;
    int         sh;
    logic [2:0] idx;
    wb_res_t    r;
    e = '0;
    e.arch = cur;
    if (p.exc) begin
        e.strb.exc      = 1'b1;
        e.strb.exc_type = p.exc_type;
        e.strb.exc_eip  = p.eip;
        return e;
    end
    e.arch.eflags      = p.eflags;
    e.arch.retired_eip = p.eip;
    lanes = (9'd1 << (4'd1 << p.ressize)) - 9'd1;  // 1, 2, 4 or 8 bytes.
    for (int s = 0; s < NUM_SLOTS; s++) begin
        r   = p.res[s];
        idx = r.dest.reg_view.idx;
        sh  = (r.is_reg && p.ressize == SZ_BYTE && r.dest.reg_view.hi_byte) ? 1 : 0;
        for (int b = 0; b < 8; b++) begin
            if (r.wb && lanes[b]) begin
                if (r.is_reg && b + sh < 4) begin
                    e.arch.gpr[idx][8*(b+sh) +: 8] = r.data[8*b +: 8];
                end else if (r.is_seg && b < 2 && idx < 3'd6) begin
                    e.arch.seg[idx][8*b +: 8] = r.data[8*b +: 8];
                end else if (r.is_mem) begin
                    e.strb.mem_be[b]         = 1'b1;
                    e.strb.mem_data[8*b +: 8] = r.data[8*b +: 8];
                end
            end
        end
        if (r.wb && r.is_mem) begin
            e.strb.mem_wr   = 1'b1;
            e.strb.mem_addr = r.dest.mem_view;
        end
    end
    if (p.br_valid && !p.br_correct) begin
        e.strb.redirect     = 1'b1;
        e.strb.redirect_eip = p.br_taken ? p.br_fip : p.br_fip_p1;
    end
    return e;
endfunction

// one clock edge of the stage, from the inputs applied before it.
task automatic advance_model(logic rst_now, logic ld_now, logic clr_now, ex_wb_pkt_t pkt_now);
    expect_t e;
    if (rst_now) begin
        arch_q     = '0;
        strb_q     = '0;
        pend       = '0;
        pend_fresh = 1'b0;
    end else begin
        if (pend.valid && pend_fresh) begin
            e      = expect_commit(arch_q, pend);
            arch_q = e.arch;
            strb_q = e.strb;
        end else begin
            strb_q = '0;
        end
        pend_fresh = ld_now && !clr_now;  // commits once per load.
        if (clr_now) begin
            pend.valid = 1'b0;
        end else if (ld_now) begin
            pend = pkt_now;
        end
    end
endtask

`endif

// ==== verif/tb_wb_stage.sv ====
`default_nettype none

module tb_wb_stage;
    timeunit 1ns;
    timeprecision 1ps;
    import wb_pkg::*;

    localparam int NUM_SLOTS      = 4;
    localparam int CLK_PERIOD     = 10;
    localparam int RESET_CYCLES   = 5;
    localparam int SETTLE_CYCLES  = 9;   // lets the read ports sweep every register.
    localparam int DIRECTED_STEPS = 20;
    localparam int RAND_PKTS      = 60;
    localparam int TOTAL_CYCLES   = RESET_CYCLES + DIRECTED_STEPS * (SETTLE_CYCLES + 1)
                                    + RAND_PKTS * 3;

    logic                clk;
    logic                rst;
    logic                ld;
    logic                clr;
    ex_wb_pkt_t          pkt_in;
    logic [IDX_W-1:0]    gpr_raddr;
    logic [IDX_W-1:0]    seg_raddr;
    logic [GPR_W-1:0]    gpr_rdata;
    logic [SEG_W-1:0]    seg_rdata;
    logic                mem_wr;
    logic [ADDR_W-1:0]   mem_addr;
    logic [DATA_W-1:0]   mem_data;
    logic [BE_W-1:0]     mem_be;
    logic                redirect;
    logic [ADDR_W-1:0]   redirect_eip;
    logic                exc;
    logic [EXC_W-1:0]    exc_type;
    logic [ADDR_W-1:0]   exc_eip;
    logic [ADDR_W-1:0]   retired_eip;
    logic [EFLAGS_W-1:0] eflags;

    logic [15:0] lfsr;
    int          checks;
    int          errors;
    int          tests;

    `include "wb_model.svh"

    wb_stage #(.NUM_SLOTS(NUM_SLOTS)) wb_stage_i (
        .clk(clk), .rst(rst), .ld(ld), .clr(clr), .pkt_in(pkt_in),
        .gpr_raddr(gpr_raddr), .seg_raddr(seg_raddr),
        .gpr_rdata(gpr_rdata), .seg_rdata(seg_rdata),
        .mem_wr(mem_wr), .mem_addr(mem_addr), .mem_data(mem_data), .mem_be(mem_be),
        .redirect(redirect), .redirect_eip(redirect_eip),
        .exc(exc), .exc_type(exc_type), .exc_eip(exc_eip),
        .retired_eip(retired_eip), .eflags(eflags)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // read ports walk the register files, one entry per cycle.
    always @(posedge clk) begin
        gpr_raddr <= gpr_raddr + 3'd1;
        seg_raddr <= (seg_raddr == 3'd5) ? 3'd0 : seg_raddr + 3'd1;
    end

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [63:0] rand_bits(int n);
        logic [63:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[62:0], fb};
        end
        return v;
    endfunction

    task automatic check(string name, logic [63:0] got, logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic compare_outputs();
        check("mem_wr", 64'(mem_wr), 64'(strb_q.mem_wr));
        check("redirect", 64'(redirect), 64'(strb_q.redirect));
        check("exc", 64'(exc), 64'(strb_q.exc));
        check("retired_eip", 64'(retired_eip), 64'(arch_q.retired_eip));
        check("eflags", 64'(eflags), 64'(arch_q.eflags));
        check($sformatf("gpr[%0d]", gpr_raddr), 64'(gpr_rdata), 64'(arch_q.gpr[gpr_raddr]));
        check($sformatf("seg[%0d]", seg_raddr), 64'(seg_rdata), 64'(arch_q.seg[seg_raddr]));
        if (strb_q.mem_wr) begin
            check("mem_addr", 64'(mem_addr), 64'(strb_q.mem_addr));
            check("mem_data", mem_data, strb_q.mem_data);
            check("mem_be", 64'(mem_be), 64'(strb_q.mem_be));
        end
        if (strb_q.redirect) begin
            check("redirect_eip", 64'(redirect_eip), 64'(strb_q.redirect_eip));
        end
        if (strb_q.exc) begin
            check("exc_type", 64'(exc_type), 64'(strb_q.exc_type));
            check("exc_eip", 64'(exc_eip), 64'(strb_q.exc_eip));
        end
    endtask

    // outputs are settled at the falling edge.
    initial begin
        forever begin
            @(negedge clk);
            if (!rst) begin
                compare_outputs();
            end
            advance_model(rst, ld, clr, pkt_in);
        end
    end

    initial begin
        #(TOTAL_CYCLES * 2 * CLK_PERIOD);
        $display("timeout: run still going after %0d cycles", TOTAL_CYCLES * 2);
        $display("SOME TESTS FAILED");
        $finish;
    end

    function automatic ex_wb_pkt_t base_pkt(logic [31:0] eip, res_size_t sz);
        ex_wb_pkt_t p;
        p         = '0;
        p.valid   = 1'b1;
        p.eip     = eip;
        p.eflags  = eip[17:0] ^ 18'h25a5a;
        p.ressize = sz;
        return p;
    endfunction

    function automatic wb_res_t reg_res(logic [2:0] idx, logic hi, logic [63:0] data);
        wb_res_t r;
        r                     = '0;
        r.wb                  = 1'b1;
        r.is_reg              = 1'b1;
        r.data                = data;
        r.dest.mem_view       = 32'hdead_b000;  // junk in the padding.
        r.dest.reg_view.hi_byte = hi;
        r.dest.reg_view.idx   = idx;
        return r;
    endfunction

    function automatic wb_res_t seg_res(logic [2:0] idx, logic [63:0] data);
        wb_res_t r;
        r                   = '0;
        r.wb                = 1'b1;
        r.is_seg            = 1'b1;
        r.data              = data;
        r.dest.reg_view.idx = idx;
        return r;
    endfunction

    function automatic wb_res_t mem_res(logic [31:0] addr, logic [63:0] data);
        wb_res_t r;
        r               = '0;
        r.wb            = 1'b1;
        r.is_mem        = 1'b1;
        r.data          = data;
        r.dest.mem_view = addr;
        return r;
    endfunction

    // one kind per slot, at most one store, quadword only alone in memory.
    function automatic ex_wb_pkt_t rand_pkt();
        ex_wb_pkt_t p;
        logic [1:0] kind;
        logic       mem_used;
        p            = base_pkt(32'(rand_bits(32)), res_size_t'(rand_bits(2)));
        p.eflags     = 18'(rand_bits(18));
        p.exc        = (rand_bits(3) == 64'd0);
        p.exc_type   = 4'(rand_bits(4));
        p.br_valid   = rand_bits(1) != 64'd0;
        p.br_taken   = rand_bits(1) != 64'd0;
        p.br_correct = rand_bits(1) != 64'd0;
        p.br_fip_p1  = 32'(rand_bits(32));
        p.br_fip     = 32'(rand_bits(32));
        mem_used     = 1'b0;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            kind = 2'(rand_bits(2));
            if ((p.ressize == SZ_QWORD && kind != 2'd3) || (kind == 2'd3 && mem_used)) begin
                kind = 2'd0;
            end
            case (kind)
                2'd1: p.res[s] = reg_res(3'(rand_bits(3)), rand_bits(1) != 64'd0, rand_bits(64));
                2'd2: p.res[s] = seg_res(3'(rand_bits(8) % 64'd6), rand_bits(64));
                2'd3: p.res[s] = mem_res(32'(rand_bits(32)), rand_bits(64));
                default: p.res[s] = '0;
            endcase
            p.res[s].data = (kind == 2'd0) ? rand_bits(64) : p.res[s].data;
            mem_used      = mem_used | (kind == 2'd3);
        end
        return p;
    endfunction

    // stimulus tasks start and end just after a rising edge.
    task automatic load(ex_wb_pkt_t p);
        ld     <= 1'b1;
        clr    <= 1'b0;
        pkt_in <= p;
        @(posedge clk);
    endtask

    task automatic idle(int n);
        ld  <= 1'b0;
        clr <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic flush();
        ld  <= 1'b0;
        clr <= 1'b1;
        @(posedge clk);
        clr <= 1'b0;
    endtask

    task automatic report_test(string name, int err_mark);
        tests++;
        if (errors == err_mark) begin
            $display("test %-22s ok", name);
        end else begin
            $display("test %-22s %0d mismatches", name, errors - err_mark);
        end
    endtask

    initial begin
        int         err_mark;
        ex_wb_pkt_t p;
        ex_wb_pkt_t q;
        rst       = 1'b1;
        ld        = 1'b0;
        clr       = 1'b0;
        pkt_in    = '0;
        gpr_raddr = '0;
        seg_raddr = '0;
        lfsr      = 16'd8;
        checks    = 0;
        errors    = 0;
        tests     = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        err_mark = errors;
        idle(SETTLE_CYCLES);
        report_test("reset state", err_mark);

        err_mark = errors;
        p = base_pkt(32'h0000_1000, SZ_DWORD);
        p.res[0] = reg_res(3'd0, 1'b0, 64'h5a5a_5a5a_1122_3344);
        p.res[1] = reg_res(3'd1, 1'b1, 64'hffff_0000_aabb_ccdd);
        load(p);
        idle(SETTLE_CYCLES);
        p = base_pkt(32'h0000_1004, SZ_BYTE);
        p.res[0] = reg_res(3'd0, 1'b0, 64'h0000_0000_0000_9955);
        p.res[1] = reg_res(3'd0, 1'b1, 64'h0000_0000_0000_8866);
        p.res[2] = reg_res(3'd7, 1'b1, 64'h1234_5678_9abc_de77);
        load(p);
        idle(SETTLE_CYCLES);
        p = base_pkt(32'h0000_1008, SZ_WORD);
        p.res[0] = reg_res(3'd2, 1'b0, 64'h0000_0000_0000_1234);
        p.res[1] = reg_res(3'd1, 1'b1, 64'h0000_0000_5555_9876);
        p.res[3] = reg_res(3'd2, 1'b0, 64'h0000_0000_7777_beef);  // later slot wins.
        load(p);
        idle(SETTLE_CYCLES);
        report_test("sized gpr writes", err_mark);

        err_mark = errors;
        p = base_pkt(32'h0000_2000, SZ_WORD);
        p.res[0] = seg_res(3'd3, 64'h0000_0000_9999_abcd);
        p.res[1] = seg_res(3'd5, 64'h0000_0000_0000_4321);
        p.res[2] = mem_res(32'h1000_0010, 64'h0123_4567_89ab_cdef);
        load(p);
        idle(SETTLE_CYCLES);
        p = base_pkt(32'h0000_2004, SZ_QWORD);
        p.res[3] = mem_res(32'h1000_0018, 64'hfedc_ba98_7654_3210);
        load(p);
        idle(SETTLE_CYCLES);
        p = base_pkt(32'h0000_2008, SZ_DWORD);
        p.res[0] = seg_res(3'd0, 64'h1111_2222_3333_4444);
        p.res[1] = mem_res(32'h2000_0000, 64'h0bad_f00d_cafe_babe);
        load(p);
        idle(SETTLE_CYCLES);
        report_test("segments and store", err_mark);

        err_mark = errors;
        p = base_pkt(32'h0000_3000, SZ_DWORD);
        p.exc        = 1'b1;
        p.exc_type   = 4'hd;
        p.br_valid   = 1'b1;
        p.br_fip_p1  = 32'h0000_3004;
        p.res[0] = reg_res(3'd4, 1'b0, 64'h0000_0000_dead_beef);
        p.res[1] = seg_res(3'd1, 64'h0000_0000_0000_7777);
        p.res[2] = mem_res(32'h3000_0000, 64'h1);
        load(p);
        idle(SETTLE_CYCLES);
        p = base_pkt(32'h0000_3010, SZ_BYTE);
        p.res[0] = reg_res(3'd4, 1'b1, 64'h0000_0000_0000_00a5);
        load(p);
        idle(SETTLE_CYCLES);
        report_test("exception", err_mark);

        err_mark = errors;
        p = base_pkt(32'h0000_4000, SZ_DWORD);
        p.br_valid  = 1'b1;
        p.br_taken  = 1'b1;
        p.br_fip    = 32'h0000_8000;
        p.br_fip_p1 = 32'h0000_4004;
        load(p);
        idle(SETTLE_CYCLES);
        p.eip      = 32'h0000_4100;
        p.br_taken = 1'b0;
        load(p);
        idle(SETTLE_CYCLES);
        p.eip        = 32'h0000_4200;
        p.br_taken   = 1'b1;
        p.br_correct = 1'b1;
        load(p);
        idle(SETTLE_CYCLES);
        report_test("branch resolution", err_mark);

        err_mark = errors;
        p = base_pkt(32'h0000_5000, SZ_WORD);
        p.res[0] = mem_res(32'h5000_0040, 64'h0000_0000_0000_c0de);
        p.res[1] = reg_res(3'd3, 1'b0, 64'h0000_0000_0000_5151);
        load(p);
        idle(4);  // stall with the packet held in the latch.
        flush();
        idle(SETTLE_CYCLES);
        q = base_pkt(32'h0000_5100, SZ_BYTE);
        q.res[2] = mem_res(32'h5000_0080, 64'h0000_0000_0000_00ee);
        load(q);
        flush();
        idle(SETTLE_CYCLES);
        p.eip = 32'h0000_5200;
        q.eip = 32'h0000_5204;
        load(p);
        load(q);
        idle(SETTLE_CYCLES);
        report_test("stall and flush", err_mark);

        err_mark = errors;
        for (int i = 0; i < RAND_PKTS; i++) begin
            load(rand_pkt());
            idle(int'(rand_bits(2) % 64'd3));
        end
        idle(SETTLE_CYCLES);
        report_test("random packets", err_mark);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+verif
source/wb_pkg.sv
source/e_wb_latch.sv
source/wb_slot.sv
source/wb_commit.sv
source/wb_stage.sv
verif/tb_wb_stage.sv
